// ==== testbench/ctrl_cases.txt ====
# vld instr rs1 rnd | inst_type op2_sel alu_opmode slide_amount up_down wdata_width inst_delay
# | vl sew lmul (all hex, rnd=1 replaces rs1 and skips the slide_amount check)
000 00000000 00000000 0 7 3 00 00000001 1 3 7 00000080 2 0 # idle right after reset
800 005572d7 0000002c 0 7 3 00 00000001 1 3 7 0000002c 1 1 # vsetvli avl from rs1, e16 m2
800 003070d7 00000000 1 7 3 00 00000001 1 2 7 00001000 0 3 # vsetvli vlmax, e8 m8
800 026071d7 00000000 1 7 3 00 00000001 1 1 7 00000040 1 6 # vsetvli vlmax, e16 mf4
800 00807057 00000000 0 7 3 00 00000001 1 2 7 00000040 2 0 # rs1=x0 rd=x0 keeps vl
800 806071d7 00000051 0 7 3 00 00000001 1 3 7 00000100 2 1 # vsetvl, vtype from rs1
008 3e056427 00001000 0 2 3 00 00000001 0 3 7 00000100 2 1 # store beats slidedown funct6
004 0e056427 00001000 0 3 3 00 00000001 1 3 7 00000100 2 1 # indexed store
020 02056407 00002000 0 4 3 00 00000001 1 3 7 00000100 2 1 # unit-stride load
010 0c056407 00002000 0 5 3 00 00000001 1 3 7 00000100 2 1 # indexed load
100 022180d7 00000000 0 0 0 01 00000001 1 3 7 00000100 2 1 # vadd.vv
080 9622e0d7 00000000 1 0 1 20 00000001 1 3 7 00000100 2 1 # vmul.vx
040 0240a157 00000000 0 1 0 01 00000001 1 3 7 00000100 2 1 # vredsum.vs
100 c6408157 00000000 0 1 0 01 00000001 1 0 7 00000100 2 1 # vwredsum.vs, widened
040 ee40a157 00000000 0 0 0 20 00000001 1 0 7 00000100 2 1 # vwmul, mul but no reduction
200 3a23b0d7 00000000 0 6 2 00 00000007 1 3 7 00000100 2 1 # vslideup.vi by 7
400 3e22c0d7 00000000 1 6 1 00 00000000 0 3 7 00000100 2 1 # vslidedown.vx, random rs1
400 3e22c0d7 00000025 0 6 1 00 00000025 0 3 7 00000100 2 1 # vslidedown.vx by rs1
040 8240a157 00000000 0 0 0 00 00000001 1 3 7 00000100 2 1 # vdivu, not in table

// ==== vlog.f ====
src/vec_isa_pkg.sv
src/vec_ctrl_pkg.sv
src/vector_instr_decoder.sv
src/alu_opmode_decoder.sv
src/vector_config_unit.sv
src/vector_ctrl_unit.sv
testbench/tb_clock_gen.sv
testbench/vector_ctrl_unit_tb.sv

// ==== testbench/vector_ctrl_unit_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module vector_ctrl_unit_tb;

   localparam int RESET_CYCLES    = 10;
   localparam int EDGE_TIMEOUT_NS = 100; // many clock periods, edge is late only if clock died
   localparam int NUM_COLS        = 14;  // columns per case line

   // one line of the case file, every column widened to 32 bits
   typedef struct packed {
      logic [31:0] vld;
      logic [31:0] instr;
      logic [31:0] rs1;
      logic [31:0] rnd;           // 1 = rs1 replaced by a random value
      logic [31:0] inst_type;
      logic [31:0] op2_sel;
      logic [31:0] alu_opmode;
      logic [31:0] slide_amount;
      logic [31:0] up_down_slide;
      logic [31:0] wdata_width;
      logic [31:0] inst_delay;
      logic [31:0] vl;
      logic [31:0] sew;
      logic [31:0] lmul;
   } ctrl_case_t;

   logic                                clk;
   logic                                rstn;
   logic [vec_isa_pkg::VLD_W-1:0]       instr_vld;
   logic [vec_isa_pkg::XLEN-1:0]        vector_instr;
   logic [vec_isa_pkg::XLEN-1:0]        scalar_rs1;
   vec_ctrl_pkg::lane_ctrl_t            lane_ctrl;
   logic [vec_isa_pkg::XLEN-1:0]        vl;
   logic [2:0]                          sew;
   logic [2:0]                          lmul;

   int case_num;  // current line, for error lines
   int cases_run;

   tb_clock_gen #(.PERIOD_NS(8)) clock_inst (.clk_o(clk));

   vector_ctrl_unit vector_ctrl_unit_inst
   (
      .clk            (clk),
      .rstn           (rstn),
      .instr_vld_i    (instr_vld),
      .vector_instr_i (vector_instr),
      .scalar_rs1_i   (scalar_rs1),
      .lane_ctrl_o    (lane_ctrl),
      .vl_o           (vl),
      .sew_o          (sew),
      .lmul_o         (lmul)
   );

   task automatic check_value(input string what, input logic [31:0] got,
                              input logic [31:0] exp);
      if (got !== exp)
      begin
         $display("[FAIL] %0t case %0d %s: got %0h, expected %0h",
                  $time, case_num, what, got, exp);
         $display("Done: errors found");
         $fatal(1);
      end
   endtask

   // each falling edge gets its own time budget
   task automatic wait_falling_edges(input int count);
      bit seen;
      int i;
      for (i = 0; i < count; i++)
      begin
         seen = 1'b0;
         fork
            begin
               @(negedge clk);
               seen = 1'b1;
            end
            #(EDGE_TIMEOUT_NS);
         join_any
         disable fork;
         if (!seen)
         begin
            $display("clock stopped, no falling edge within %0d ns", EDGE_TIMEOUT_NS);
            $display("Done: errors found");
            $fatal(1);
         end
      end
   endtask

   task automatic run_case(input ctrl_case_t tc);
      logic [31:0] rs1_val;
      rs1_val      = tc.rnd[0] ? $urandom() : tc.rs1;
      instr_vld    = tc.vld[vec_isa_pkg::VLD_W-1:0]; // driven on the falling edge
      vector_instr = tc.instr;
      scalar_rs1   = rs1_val;
      wait_falling_edges(1); // sampled on the rising edge in between
      check_value("inst_type", 32'(lane_ctrl.inst_type), tc.inst_type);
      check_value("op2_sel", 32'(lane_ctrl.op2_sel), tc.op2_sel);
      check_value("alu_opmode", 32'(lane_ctrl.alu_opmode), tc.alu_opmode);
      if (!tc.rnd[0])
         check_value("slide_amount", lane_ctrl.slide_amount, tc.slide_amount);
      check_value("up_down_slide", 32'(lane_ctrl.up_down_slide), tc.up_down_slide);
      check_value("wdata_width", 32'(lane_ctrl.wdata_width), tc.wdata_width);
      check_value("inst_delay", 32'(lane_ctrl.inst_delay), tc.inst_delay);
      check_value("alu_imm", 32'(lane_ctrl.alu_imm), 32'(tc.instr[19:15])); // imm field
      check_value("alu_x_data", lane_ctrl.alu_x_data, rs1_val); // scalar as driven
      check_value("vector_mask", 32'(lane_ctrl.vector_mask), 32'(!tc.instr[25])); // vm clear = masked
      // strobe is one-hot, so the flag goes with the reduction class
      check_value("reduction_op", 32'(lane_ctrl.reduction_op),
                  32'(tc.inst_type == 32'(vec_ctrl_pkg::inst_reduction)));
      instr_vld    = '0; // idle slot while config settles
      vector_instr = '0;
      scalar_rs1   = '0;
      wait_falling_edges(1); // vtype / vl registered one edge after decode
      check_value("vl", vl, tc.vl);
      check_value("sew", 32'(sew), tc.sew);
      check_value("lmul", 32'(lmul), tc.lmul);
   endtask

   initial
   begin
      int fd;
      int n;
      string line;
      ctrl_case_t tc;
      rstn         = 1'b0;
      instr_vld    = '0;
      vector_instr = '0;
      scalar_rs1   = '0;
      case_num     = 0;
      cases_run    = 0;
      void'($urandom(14)); // fixed seed for the random rs1 lines
      wait_falling_edges(RESET_CYCLES);
      rstn = 1'b1;
      fd = $fopen("testbench/ctrl_cases.txt", "r");
      if (fd == 0)
      begin
         $display("cannot open the case file testbench/ctrl_cases.txt");
         $display("Done: errors found");
         $fatal(1);
      end
      while (!$feof(fd))
      begin
         line = "";
         n = $fgets(line, fd);
         n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                     tc.vld, tc.instr, tc.rs1, tc.rnd, tc.inst_type, tc.op2_sel,
                     tc.alu_opmode, tc.slide_amount, tc.up_down_slide, tc.wdata_width,
                     tc.inst_delay, tc.vl, tc.sew, tc.lmul);
         if (n == NUM_COLS)
         begin
            case_num++;
            run_case(tc);
            cases_run++;
         end
         else if (n > 0)
         begin
            $display("case file line has %0d of %0d columns: %s", n, NUM_COLS, line);
            $display("Done: errors found");
            $fatal(1);
         end
      end
      $fclose(fd);
      if (cases_run == 0)
      begin
         $display("no cases found in the case file");
         $display("Done: errors found");
         $fatal(1);
      end
      else
      begin
         $display("Done: no errors");
         $finish;
      end
   end

endmodule

`default_nettype wire

// ==== testbench/tb_clock_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen
#(
   parameter int PERIOD_NS = 8
)
(
   output logic clk_o
);

   initial
   begin
      clk_o = 1'b1; // starts high, so the first edge seen is a falling one
      forever
      begin
         #(PERIOD_NS / 2) clk_o = ~clk_o; // half period per phase
      end
   end

endmodule

`default_nettype wire

// ==== src/vector_ctrl_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module vector_ctrl_unit
(
   input  wire logic                           clk,
   input  wire logic                           rstn,
   input  wire logic [vec_isa_pkg::VLD_W-1:0]  instr_vld_i,
   input  wire logic [vec_isa_pkg::XLEN-1:0]   vector_instr_i,
   input  wire logic [vec_isa_pkg::XLEN-1:0]   scalar_rs1_i,
   output vec_ctrl_pkg::lane_ctrl_t            lane_ctrl_o,
   output logic [vec_isa_pkg::XLEN-1:0]        vl_o,
   output logic [2:0]                          sew_o,
   output logic [2:0]                          lmul_o
);

   logic [vec_isa_pkg::XLEN-1:0]  instr_q;    // registered instruction
   logic [vec_isa_pkg::XLEN-1:0]  rs1_q;      // registered scalar
   logic                          cfg_strobe;
   vec_ctrl_pkg::op_group_e       op_group;
   logic [5:0]                    funct6;
   logic                          reduction;
   vec_ctrl_pkg::alu_opmode_e     alu_opmode;
   logic [3:0]                    inst_delay;
   vec_ctrl_pkg::vtype_t          vtype;

   vector_instr_decoder decoder_inst
   (
      .clk            (clk),
      .rstn           (rstn),
      .instr_vld_i    (instr_vld_i),
      .vector_instr_i (vector_instr_i),
      .scalar_rs1_i   (scalar_rs1_i),
      .sew_i          (vtype.sew), // current sew, before any pending update
      .alu_opmode_i   (alu_opmode),
      .inst_delay_i   (inst_delay),
      .instr_o        (instr_q),
      .rs1_o          (rs1_q),
      .cfg_strobe_o   (cfg_strobe),
      .op_group_o     (op_group),
      .funct6_o       (funct6),
      .reduction_o    (reduction),
      .lane_ctrl_o    (lane_ctrl_o)
   );

   alu_opmode_decoder alu_dec_inst
   (
      .op_group_i   (op_group),
      .funct6_i     (funct6),
      .reduction_i  (reduction),
      .alu_opmode_o (alu_opmode),
      .inst_delay_o (inst_delay)
   );

   vector_config_unit cfg_inst
   (
      .clk          (clk),
      .rstn         (rstn),
      .cfg_strobe_i (cfg_strobe),
      .instr_i      (instr_q),
      .rs1_i        (rs1_q),
      .vtype_o      (vtype),
      .vl_o         (vl_o)
   );

   assign sew_o  = vtype.sew;
   assign lmul_o = vtype.lmul;

endmodule

`default_nettype wire

// ==== src/vector_config_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module vector_config_unit
(
   input  wire logic                           clk,
   input  wire logic                           rstn,
   input  wire logic                           cfg_strobe_i,
   input  wire logic [vec_isa_pkg::XLEN-1:0]   instr_i,
   input  wire logic [vec_isa_pkg::XLEN-1:0]   rs1_i,
   output vec_ctrl_pkg::vtype_t                vtype_o,
   output logic [vec_isa_pkg::XLEN-1:0]        vl_o
);

   vec_ctrl_pkg::vtype_t            vtype_next;
   vec_isa_pkg::vlmax_t             vlmax;      // for the incoming vtype
   logic [vec_isa_pkg::XLEN-1:0]    vl_next;

   always_comb
   begin
      vtype_next = '0;
      if (instr_i[31:30] == vec_isa_pkg::VSETVL_TAG)
      begin
         // vsetvl, vtype csr image comes in on rs1
         vtype_next.vill     = rs1_i[31];
         vtype_next.reserved = {1'b0, rs1_i[30:8]};
         vtype_next.vma      = rs1_i[7];
         vtype_next.vta      = rs1_i[6];
         vtype_next.sew      = rs1_i[5:3];
         vtype_next.lmul     = rs1_i[2:0];
      end
      else
      begin
         // vsetvli, zimm sits in the instruction
         vtype_next.lmul = {instr_i[25], instr_i[21:20]};
         vtype_next.sew  = instr_i[24:22];
         vtype_next.vta  = instr_i[26];
         vtype_next.vma  = instr_i[27];
         vtype_next.vill = instr_i[30];
      end
   end

   assign vlmax = vec_isa_pkg::vlmax_lookup(vtype_next.lmul, vtype_next.sew);

   // rs1 != x0 takes avl from rs1, rd != x0 with rs1 == x0 asks for vlmax
   assign vl_next = (instr_i[19:15] != 5'd0) ? rs1_i
                  : (instr_i[11:7] != 5'd0)
                  ? {{(vec_isa_pkg::XLEN - vec_isa_pkg::VLMAX_W){1'b0}}, vlmax}
                  : vl_o; // keep current vl

   always_ff @(posedge clk)
   begin
      if (!rstn)
      begin
         vtype_o <= vec_ctrl_pkg::VTYPE_RESET;
         vl_o    <= vec_isa_pkg::RESET_VL;
      end
      else if (cfg_strobe_i)
      begin
         vtype_o <= vtype_next;
         vl_o    <= vl_next;
      end
   end

   // table path never yields more elements than bits in a register
   assert property (@(posedge clk) disable iff (!rstn)
                    cfg_strobe_i && instr_i[19:15] == 5'd0 |=> vl_o <= vec_isa_pkg::VLEN)
      else $error("vl above VLEN after vlmax update");

endmodule

`default_nettype wire

// ==== src/alu_opmode_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu_opmode_decoder
(
   input  wire vec_ctrl_pkg::op_group_e    op_group_i,
   input  wire logic [5:0]                 funct6_i,
   input  wire logic                       reduction_i,
   output vec_ctrl_pkg::alu_opmode_e       alu_opmode_o,
   output logic [3:0]                      inst_delay_o
);

   vec_ctrl_pkg::alu_opmode_e opi_op; // integer group lookup
   vec_ctrl_pkg::alu_opmode_e opm_op; // mask / multiply / widening lookup

   always_comb
   begin
      opi_op = vec_ctrl_pkg::nop_op;
      case (funct6_i)
         6'b000000, 6'b100001: opi_op = vec_ctrl_pkg::add_op; // vadd, vsadd
         6'b010000, 6'b010001: opi_op = vec_ctrl_pkg::add_op; // vadc, vmadc
         6'b110000, 6'b110001: opi_op = vec_ctrl_pkg::add_op; // widening reductions
         6'b000010, 6'b000011: opi_op = vec_ctrl_pkg::sub_op; // vsub, vrsub
         6'b010010, 6'b010011: opi_op = vec_ctrl_pkg::sub_op; // vsbc, vmsbc
         6'b100011:            opi_op = vec_ctrl_pkg::sub_op; // vssub
         6'b100000:            opi_op = vec_ctrl_pkg::addu_op; // vsaddu
         6'b100010:            opi_op = vec_ctrl_pkg::subu_op;
         6'b000100, 6'b011010: opi_op = vec_ctrl_pkg::sltu_op; // vminu, vmsltu
         6'b000101, 6'b011011: opi_op = vec_ctrl_pkg::slt_op;
         6'b000110, 6'b011110: opi_op = vec_ctrl_pkg::sgtu_op; // vmaxu, vmsgtu
         6'b000111, 6'b011111: opi_op = vec_ctrl_pkg::sgt_op;
         6'b001001:            opi_op = vec_ctrl_pkg::and_op;
         6'b001010:            opi_op = vec_ctrl_pkg::or_op;
         6'b001011:            opi_op = vec_ctrl_pkg::xor_op;
         6'b011000:            opi_op = vec_ctrl_pkg::seq_op;  // vmseq
         6'b011001:            opi_op = vec_ctrl_pkg::sneq_op; // vmsne
         6'b011100:            opi_op = vec_ctrl_pkg::sleu_op;
         6'b011101:            opi_op = vec_ctrl_pkg::sle_op;
         6'b100101:            opi_op = vec_ctrl_pkg::sll_op;
         6'b100111:            opi_op = vec_ctrl_pkg::mul_op;  // vsmul
         6'b101000, 6'b101010: opi_op = vec_ctrl_pkg::srl_op; // vsrl, vssrl
         6'b101100, 6'b101110: opi_op = vec_ctrl_pkg::srl_op; // vnsrl, vnclipu
         6'b101111:            opi_op = vec_ctrl_pkg::srl_op; // vnclip
         6'b101001, 6'b101011: opi_op = vec_ctrl_pkg::sra_op; // vsra, vssra
         6'b101101:            opi_op = vec_ctrl_pkg::sra_op; // vnsra
         default:              opi_op = vec_ctrl_pkg::nop_op; // slides, gathers, reserved
      endcase
   end

   always_comb
   begin
      opm_op = vec_ctrl_pkg::nop_op;
      case (funct6_i)
         6'b000000, 6'b001001: opm_op = vec_ctrl_pkg::add_op; // vredsum, vaadd
         6'b000001, 6'b011001: opm_op = vec_ctrl_pkg::and_op; // vredand, vmand
         6'b000010, 6'b011010: opm_op = vec_ctrl_pkg::or_op;
         6'b000011, 6'b011011: opm_op = vec_ctrl_pkg::xor_op;
         6'b000100:            opm_op = vec_ctrl_pkg::sltu_op; // vredminu
         6'b000101:            opm_op = vec_ctrl_pkg::slt_op;
         6'b000110:            opm_op = vec_ctrl_pkg::sgtu_op; // vredmaxu
         6'b000111:            opm_op = vec_ctrl_pkg::sgt_op;
         6'b001000:            opm_op = vec_ctrl_pkg::addu_op; // vaaddu
         6'b001010:            opm_op = vec_ctrl_pkg::subu_op;
         6'b001011:            opm_op = vec_ctrl_pkg::sub_op;
         6'b011000:            opm_op = vec_ctrl_pkg::andnot_op; // mask logicals
         6'b011100:            opm_op = vec_ctrl_pkg::ornot_op;
         6'b011101:            opm_op = vec_ctrl_pkg::nand_op;
         6'b011110:            opm_op = vec_ctrl_pkg::nor_op;
         6'b011111:            opm_op = vec_ctrl_pkg::xnor_op;
         6'b100100:            opm_op = vec_ctrl_pkg::mulhu_op;
         6'b100101, 6'b111011: opm_op = vec_ctrl_pkg::mul_op; // vmul, vwmul
         6'b100110:            opm_op = vec_ctrl_pkg::mulhsu_op;
         6'b100111:            opm_op = vec_ctrl_pkg::mulh_op;
         6'b101001, 6'b101101: opm_op = vec_ctrl_pkg::mul_add_op; // vmadd, vmacc
         6'b111101:            opm_op = vec_ctrl_pkg::mul_add_op; // vwmacc
         6'b101011, 6'b101111: opm_op = vec_ctrl_pkg::mul_sub_op; // vnmsub, vnmsac
         6'b110000, 6'b110100: opm_op = vec_ctrl_pkg::addu_op; // vwaddu, vwaddu.w
         6'b110001, 6'b110101: opm_op = vec_ctrl_pkg::add_op;
         6'b110010, 6'b110110: opm_op = vec_ctrl_pkg::subu_op;
         6'b110011, 6'b110111: opm_op = vec_ctrl_pkg::sub_op;
         6'b111000:            opm_op = vec_ctrl_pkg::mulu_op; // vwmulu
         6'b111010:            opm_op = vec_ctrl_pkg::mulsu_op; // vwmulsu
         6'b111100:            opm_op = vec_ctrl_pkg::mulu_add_op; // vwmaccu
         6'b111110:            opm_op = vec_ctrl_pkg::mulus_add_op;
         6'b111111:            opm_op = vec_ctrl_pkg::mulsu_add_op;
         default:              opm_op = vec_ctrl_pkg::nop_op; // div/rem, unary, slide1
      endcase
   end

   always_comb
   begin
      case (op_group_i)
         vec_ctrl_pkg::grp_opi: alu_opmode_o = opi_op;
         vec_ctrl_pkg::grp_opm: alu_opmode_o = opm_op;
         default:               alu_opmode_o = vec_ctrl_pkg::nop_op; // loads, stores, config
      endcase
   end

   // multiply reductions need one more stage in the lane alu
   assign inst_delay_o = (reduction_i && alu_opmode_o[6:5] == vec_ctrl_pkg::MUL_CLASS_TAG)
                       ? vec_ctrl_pkg::ALU_DELAY_MUL : vec_ctrl_pkg::ALU_DELAY;

endmodule

`default_nettype wire

// ==== src/vector_instr_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module vector_instr_decoder
(
   input  wire logic                                   clk,
   input  wire logic                                   rstn,
   input  wire logic [vec_isa_pkg::VLD_W-1:0]          instr_vld_i,
   input  wire logic [vec_isa_pkg::XLEN-1:0]           vector_instr_i,
   input  wire logic [vec_isa_pkg::XLEN-1:0]           scalar_rs1_i,
   input  wire logic [2:0]                             sew_i,
   input  wire vec_ctrl_pkg::alu_opmode_e              alu_opmode_i,
   input  wire logic [3:0]                             inst_delay_i,
   output logic [vec_isa_pkg::XLEN-1:0]                instr_o,
   output logic [vec_isa_pkg::XLEN-1:0]                rs1_o,
   output logic                                        cfg_strobe_o,
   output vec_ctrl_pkg::op_group_e                     op_group_o,
   output logic [5:0]                                  funct6_o,
   output logic                                        reduction_o,
   output vec_ctrl_pkg::lane_ctrl_t                    lane_ctrl_o
);

   logic [vec_isa_pkg::VLD_W-1:0] strobe_q; // registered class strobe
   logic is_slide;
   logic widening;

   always_ff @(posedge clk)
   begin
      if (!rstn)
      begin
         strobe_q <= '0;
         instr_o  <= '0;
         rs1_o    <= '0;
      end
      else
      begin
         strobe_q <= instr_vld_i; // sampled every clock, no handshake
         instr_o  <= vector_instr_i;
         rs1_o    <= scalar_rs1_i;
      end
   end

   assign cfg_strobe_o = strobe_q[vec_isa_pkg::CFG_BIT];
   assign funct6_o     = instr_o[31:26];

   assign op_group_o = (strobe_q[10:8] != '0) ? vec_ctrl_pkg::grp_opi : // opivv/opivi/opivx
                       (strobe_q[7:6] != '0)  ? vec_ctrl_pkg::grp_opm : // opmvv/opmvx
                                                vec_ctrl_pkg::grp_none;

   // reductions live at funct6 000xxx in opm and 110xxx (widening) in opivv
   assign reduction_o = ((strobe_q[vec_isa_pkg::OPMVV_BIT] || strobe_q[vec_isa_pkg::OPMVX_BIT])
                         && funct6_o[5:3] == 3'b000)
                     || (strobe_q[vec_isa_pkg::OPIVV_BIT] && funct6_o[5:3] == 3'b110);

   assign is_slide = !cfg_strobe_o && (funct6_o == vec_isa_pkg::FUNCT6_SLIDEUP
                                    || funct6_o == vec_isa_pkg::FUNCT6_SLIDEDOWN);
   assign widening = funct6_o[5:4] == 2'b11; // 11x, result is 2*sew

   always_comb
   begin
      // class priority, memory ops first
      if (strobe_q[vec_isa_pkg::STORE_BIT])
         lane_ctrl_o.inst_type = vec_ctrl_pkg::inst_store;
      else if (strobe_q[vec_isa_pkg::IDX_STORE_BIT])
         lane_ctrl_o.inst_type = vec_ctrl_pkg::inst_idx_store;
      else if (strobe_q[vec_isa_pkg::LOAD_BIT])
         lane_ctrl_o.inst_type = vec_ctrl_pkg::inst_load;
      else if (strobe_q[vec_isa_pkg::IDX_LOAD_BIT])
         lane_ctrl_o.inst_type = vec_ctrl_pkg::inst_idx_load;
      else if (reduction_o)
         lane_ctrl_o.inst_type = vec_ctrl_pkg::inst_reduction;
      else if (is_slide)
         lane_ctrl_o.inst_type = vec_ctrl_pkg::inst_slide;
      else if (strobe_q != '0 && !cfg_strobe_o)
         lane_ctrl_o.inst_type = vec_ctrl_pkg::inst_normal;
      else
         lane_ctrl_o.inst_type = vec_ctrl_pkg::inst_invalid; // config or idle

      // operand 2 source
      if (strobe_q[vec_isa_pkg::OPIVV_BIT] || strobe_q[vec_isa_pkg::OPMVV_BIT])
         lane_ctrl_o.op2_sel = vec_ctrl_pkg::op2_vector;
      else if (strobe_q[vec_isa_pkg::OPIVX_BIT] || strobe_q[vec_isa_pkg::OPMVX_BIT])
         lane_ctrl_o.op2_sel = vec_ctrl_pkg::op2_scalar;
      else if (strobe_q[vec_isa_pkg::OPIVI_BIT])
         lane_ctrl_o.op2_sel = vec_ctrl_pkg::op2_imm;
      else
         lane_ctrl_o.op2_sel = vec_ctrl_pkg::op2_none;

      // slide offset, uimm for .vi, rs1 for .vx, else one element
      if (strobe_q[vec_isa_pkg::OPIVI_BIT])
         lane_ctrl_o.slide_amount = {27'd0, instr_o[19:15]};
      else if (strobe_q[vec_isa_pkg::OPIVX_BIT])
         lane_ctrl_o.slide_amount = rs1_o;
      else
         lane_ctrl_o.slide_amount = 32'd1;

      lane_ctrl_o.up_down_slide = funct6_o != vec_isa_pkg::FUNCT6_SLIDEDOWN;
      lane_ctrl_o.alu_opmode    = alu_opmode_i; // from the alu op decoder
      lane_ctrl_o.alu_imm       = instr_o[19:15];
      lane_ctrl_o.alu_x_data    = rs1_o;
      lane_ctrl_o.vector_mask   = ~instr_o[25]; // vm = 0 means masked
      lane_ctrl_o.reduction_op  = reduction_o;
      lane_ctrl_o.wdata_width   = 2'(sew_i + (widening ? 3'd2 : 3'd1)); // bytes log2 + 1
      lane_ctrl_o.inst_delay    = inst_delay_i;
   end

   // scheduler issues one class per cycle
   assert property (@(posedge clk) disable iff (!rstn) $onehot0(strobe_q))
      else $error("more than one class strobe set");

endmodule

`default_nettype wire

// ==== src/vec_ctrl_pkg.sv ====
`default_nettype none

package vec_ctrl_pkg;

   // alu op codes, multiply class sits at bits 6:5 == 01
   typedef enum logic [8:0] {
      nop_op       = 9'd0,
      add_op, addu_op, sub_op, subu_op,
      and_op, or_op, xor_op, andnot_op, ornot_op, nand_op, nor_op, xnor_op,
      sll_op, srl_op, sra_op,
      seq_op, sneq_op, slt_op, sltu_op, sle_op, sleu_op, sgt_op, sgtu_op,
      mul_op       = 9'd32,
      mulu_op, mulh_op, mulhu_op, mulhsu_op, mulsu_op,
      mul_add_op, mul_sub_op, mulu_add_op, mulus_add_op, mulsu_add_op
   } alu_opmode_e;

   localparam logic [1:0] MUL_CLASS_TAG = 2'b01; // opcode bits 6:5
   localparam logic [3:0] ALU_DELAY     = 4'd7;  // plain alu pipe
   localparam logic [3:0] ALU_DELAY_MUL = 4'd8;  // multiply reduction, one extra stage

   typedef enum logic [2:0] {
      inst_normal    = 3'd0,
      inst_reduction = 3'd1,
      inst_store     = 3'd2,
      inst_idx_store = 3'd3,
      inst_load      = 3'd4,
      inst_idx_load  = 3'd5,
      inst_slide     = 3'd6,
      inst_invalid   = 3'd7
   } inst_type_e;

   typedef enum logic [1:0] {
      op2_vector = 2'd0,
      op2_scalar = 2'd1,
      op2_imm    = 2'd2,
      op2_none   = 2'd3
   } op2_sel_e;

   typedef enum logic [1:0] {grp_none, grp_opi, grp_opm} op_group_e;

   typedef struct packed {
      logic        vill;
      logic [23:0] reserved;
      logic        vma;
      logic        vta;
      logic [2:0]  sew;
      logic [2:0]  lmul;
   } vtype_t;

   localparam vtype_t VTYPE_RESET = '{vill: 1'b0, reserved: '0, vma: 1'b0, vta: 1'b0,
                                      sew: vec_isa_pkg::RESET_SEW,
                                      lmul: vec_isa_pkg::RESET_LMUL};

   // control word broadcast to the lanes
   typedef struct packed {
      inst_type_e                     inst_type;
      op2_sel_e                       op2_sel;
      alu_opmode_e                    alu_opmode;
      logic [4:0]                     alu_imm;
      logic [vec_isa_pkg::XLEN-1:0]   alu_x_data;
      logic                           up_down_slide; // 0 = slide down
      logic [vec_isa_pkg::XLEN-1:0]   slide_amount;
      logic                           vector_mask;
      logic                           reduction_op;
      logic [1:0]                     wdata_width;
      logic [3:0]                     inst_delay;
   } lane_ctrl_t;

endpackage

`default_nettype wire

// ==== src/vec_isa_pkg.sv ====
`default_nettype none

package vec_isa_pkg;

   localparam int VLEN  = 4096; // bits per vector register
   localparam int XLEN  = 32;   // scalar and instruction width
   localparam int VLD_W = 12;   // one-hot class strobe width

   // class strobe bit positions, one per instruction class
   localparam int IDX_STORE_BIT = 2;
   localparam int STORE_BIT     = 3;
   localparam int IDX_LOAD_BIT  = 4;
   localparam int LOAD_BIT      = 5;
   localparam int OPMVV_BIT     = 6;
   localparam int OPMVX_BIT     = 7;
   localparam int OPIVV_BIT     = 8;
   localparam int OPIVI_BIT     = 9;
   localparam int OPIVX_BIT     = 10;
   localparam int CFG_BIT       = 11; // vsetvli / vsetvl

   localparam logic [5:0] FUNCT6_SLIDEUP   = 6'b001110;
   localparam logic [5:0] FUNCT6_SLIDEDOWN = 6'b001111;

   localparam logic [1:0] VSETVL_TAG = 2'b10; // instr[31:30] of vsetvl

   // config state out of reset: sew 32, lmul 1
   localparam logic [2:0]      RESET_SEW  = 3'b010;
   localparam logic [2:0]      RESET_LMUL = 3'b000;
   localparam logic [XLEN-1:0] RESET_VL   = XLEN'(VLEN / 32);

   localparam int VLMAX_W = $clog2(VLEN) + 1; // room for VLMAX itself

   typedef logic [VLMAX_W-1:0] vlmax_t;

   // VLMAX = VLEN / SEW * LMUL, fractional lmul encoded as 5..7
   function automatic vlmax_t vlmax_lookup(input logic [2:0] lmul, input logic [2:0] sew);
      vlmax_t base;
      vlmax_t vlmax;
      base = vlmax_t'((VLEN / 8) >> sew); // elements at lmul 1
      if (sew > 3'd2 || lmul == 3'd4)
         vlmax = '0; // reserved encodings
      else if (lmul < 3'd4)
         vlmax = base << lmul; // integer lmul
      else
         vlmax = base >> (4'd8 - {1'b0, lmul}); // 1/2, 1/4, 1/8
      return vlmax;
   endfunction

endpackage

`default_nettype wire
